// File: i2c_target_top.f
design/i2c_target_pkg.sv
design/i2c_bus_monitor.sv
design/i2c_byte_fifo.sv
design/i2c_target_fsm.sv
design/i2c_target_top.sv
+incdir+bench
bench/i2c_target_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it, status follows the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module i2c_target_tb \
  -f i2c_target_top.f -o i2c_target_sim &&
./obj_dir/i2c_target_sim | tee /dev/stderr | grep -qF '*** TEST PASSED ***' &&
echo "simulation passed" ||
{
  echo "simulation failed"
  exit 1
}

// File: bench/i2c_host_tasks.svh
`ifndef I2C_HOST_TASKS_SVH
`define I2C_HOST_TASKS_SVH

task automatic wait_clk(input int n);
  repeat (n) @(posedge clk);
endtask

// let scl go and wait out any clock stretch by the target
task automatic scl_release;
  host_scl <= 1'b1;
  @(posedge clk);
  while (!scl) @(posedge clk);  // held low by the target
endtask

// one scl period: set sda in the low phase, sample mid high phase
task automatic clock_bit(input logic b, output logic s);
  wait_clk(HALF / 2);
  host_sda <= b;
  wait_clk(HALF / 2);
  scl_release();
  wait_clk(HALF / 2);
  s = sda;  // wired-and value seen by the host
  wait_clk(HALF / 2);
  host_scl <= 1'b0;
endtask

// start, or repeated start when scl is low
task automatic bus_start;
  wait_clk(HALF / 2);
  host_sda <= 1'b1;
  wait_clk(HALF / 2);
  scl_release();
  wait_clk(HALF);
  host_sda <= 1'b0;  // sda falls with scl high
  wait_clk(HALF);
  host_scl <= 1'b0;
endtask

task automatic bus_stop;
  wait_clk(HALF / 2);
  host_sda <= 1'b0;
  wait_clk(HALF / 2);
  scl_release();
  wait_clk(HALF);
  host_sda <= 1'b1;  // sda rises with scl high
  wait_clk(HALF);
endtask

// eight bits msb first, then the ack slot with sda released
task automatic write_byte(input logic [7:0] d, output logic ack);
  logic s;
  for (int i = 7; i >= 0; i--) begin
    clock_bit(d[i], s);
  end
  clock_bit(1'b1, s);
  ack = ~s;  // low in the slot means ack
endtask

// host releases sda for eight bits, then acks or nacks
task automatic read_byte(input logic last, output logic [7:0] d);
  logic s;
  d = 8'h00;
  for (int i = 7; i >= 0; i--) begin
    clock_bit(1'b1, s);
    d[i] = s;
  end
  clock_bit(last, s);  // nack on the last byte
endtask

`endif

// File: bench/i2c_target_tb.sv
`timescale 1ns/100ps

module i2c_target_tb;

  localparam int HALF      = 20;  // clocks per scl half period
  localparam int AcqDepth  = 8;
  localparam int TxDepth   = 4;
  localparam int NumTrans  = 24;
  localparam int NumDirect = 6;
  localparam int Limit     = (NumTrans + NumDirect) * 12 * 9 * 40 * 2;

  logic       clk;
  logic       rst_n;
  logic       host_scl;
  logic       host_sda;
  logic       scl;
  logic       sda;
  logic       target_enable;
  logic [6:0] addr0;
  logic [6:0] mask0;
  logic [6:0] addr1;
  logic [6:0] mask1;
  logic [15:0] thd_dat;
  logic       tx_wr;
  logic [7:0] tx_wdata;
  logic       acq_rd_i = 1'b0;  // popped by the drain process
  logic       scl_o;
  logic       sda_o;
  logic       acq_empty;
  logic       target_idle;
  logic       target_rnw;
  logic       cmd_cpl;
  logic       stretch;
  logic [3:0] acq_level;
  i2c_target_pkg::acq_entry_t acq_rdata;

  i2c_target_pkg::acq_entry_t exp_q[$];  // expected log
  logic [7:0] txq[$];                    // bytes waiting in the tx queue
  int   errors = 0;
  int   cyc = 0;
  int   cpl_cnt = 0;
  int   exp_stops = 0;
  logic drain_en = 1'b1;
  logic stretch_seen = 1'b0;

  assign scl = host_scl & scl_o;  // open-drain bus
  assign sda = host_sda & sda_o;

  i2c_target_top #(.AcqDepth(AcqDepth), .TxDepth(TxDepth)) UUT (
    .clk_i(clk), .rst_ni(rst_n), .scl_i(scl), .sda_i(sda),
    .target_enable_i(target_enable),
    .target_address0_i(addr0), .target_mask0_i(mask0),
    .target_address1_i(addr1), .target_mask1_i(mask1),
    .thd_dat_i(thd_dat), .tx_wr_i(tx_wr), .tx_wdata_i(tx_wdata), .acq_rd_i(acq_rd_i),
    .scl_o(scl_o), .sda_o(sda_o), .acq_rdata_o(acq_rdata), .acq_empty_o(acq_empty),
    .acq_level_o(acq_level), .target_idle_o(target_idle), .target_rnw_o(target_rnw),
    .event_cmd_complete_o(cmd_cpl), .event_stretch_o(stretch)
  );

  `include "i2c_host_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cmd_cpl) cpl_cnt <= cpl_cnt + 1;
    if (cyc >= Limit) begin
      $display("timeout: bus traffic did not finish within %0d cycles", Limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // pops and compares the log in order, and also while the target stretches
  always @(posedge clk) begin
    acq_rd_i <= 1'b0;
    if (rst_n && !acq_empty && !acq_rd_i && (drain_en || stretch)) begin
      if (stretch) stretch_seen <= 1'b1;
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected acquisition entry %h at %0t", acq_rdata, $time);
      end else begin
        check_val(32'(acq_rdata), 32'(exp_q.pop_front()), "acquisition entry");
      end
      acq_rd_i <= 1'b1;
    end
  end

  function automatic logic addr_matches(input logic [6:0] a);
    return ((a & mask0) == (addr0 & mask0)) || ((a & mask1) == (addr1 & mask1));
  endfunction

  function automatic i2c_target_pkg::acq_entry_t entry(input i2c_target_pkg::acq_tag_e t,
                                                       input logic [7:0] b);
    i2c_target_pkg::acq_entry_t e;
    e.tag            = t;
    e.data.data_byte = b;
    return e;
  endfunction

  function automatic logic [6:0] pick_match_addr();
    logic [6:0] r;
    r = 7'($urandom);
    if ($urandom_range(0, 1) == 0) return (addr0 & mask0) | (r & ~mask0);
    return (addr1 & mask1) | (r & ~mask1);
  endfunction

  task automatic push_tx(input logic [7:0] b);
    @(posedge clk);
    tx_wr    <= 1'b1;
    tx_wdata <= b;
    txq.push_back(b);  // model of the tx queue
    @(posedge clk);
    tx_wr    <= 1'b0;
  endtask

  task automatic idle_check(input string where);
    wait_clk(4);
    check_val(32'(target_idle), 32'(1), {"idle after ", where});
    check_val(32'({scl_o, sda_o}), 32'(3), {"lines released after ", where});
  endtask

  task automatic write_txn(input logic [6:0] a, input int n, input logic close);
    logic       ack;
    logic [7:0] b;
    bus_start();
    exp_q.push_back(entry(i2c_target_pkg::ACQ_START, {a, 1'b0}));
    write_byte({a, 1'b0}, ack);
    check_val(32'(ack), 32'(1), "write address ack");
    for (int i = 0; i < n; i++) begin
      b = 8'($urandom);
      exp_q.push_back(entry(i2c_target_pkg::ACQ_DATA, b));
      write_byte(b, ack);
      check_val(32'(ack), 32'(1), "write data ack");
    end
    if (close) begin
      exp_q.push_back(entry(i2c_target_pkg::ACQ_STOP, 8'h00));
      exp_stops++;
      bus_stop();
      idle_check("write");
    end
  endtask

  task automatic read_txn(input logic [6:0] a, input int n, input logic restart);
    logic       ack;
    logic [7:0] d;
    if (!restart) bus_start();
    exp_q.push_back(entry(restart ? i2c_target_pkg::ACQ_RESTART : i2c_target_pkg::ACQ_START,
                          {a, 1'b1}));
    write_byte({a, 1'b1}, ack);
    check_val(32'(ack), 32'(1), "read address ack");
    check_val(32'(target_rnw), 32'(1), "rnw during read");
    for (int i = 0; i < n; i++) begin
      read_byte(i == n - 1, d);
      if (txq.size() == 0) begin
        errors++;
        $display("read returned a byte that was never queued at %0t", $time);
      end else begin
        check_val(32'(d), 32'(txq.pop_front()), "read data");
      end
    end
    exp_q.push_back(entry(i2c_target_pkg::ACQ_STOP, 8'h00));
    exp_stops++;
    bus_stop();
    idle_check("read");
  endtask

  task automatic nomatch_txn(input logic [6:0] a);
    logic ack;
    bus_start();
    write_byte({a, 1'b0}, ack);
    check_val(32'(ack), 32'(0), "no ack for other address");
    bus_stop();
    idle_check("ignored address");
  endtask

  task automatic empty_tx_read(input logic [6:0] a);
    int cnt;
    cnt = 0;
    fork
      read_txn(a, 1, 1'b0);
      begin
        while (!stretch && cnt < 4 * HALF * 9) begin
          @(posedge clk);
          cnt++;
        end
        check_val(32'(stretch), 32'(1), "stretch on empty tx queue");
        push_tx(8'($urandom));  // releases the stretch
      end
    join
  endtask

  task automatic wait_drained;
    while (exp_q.size() != 0 || !acq_empty) @(posedge clk);
  endtask

  initial begin
    int         kind;
    int         n;
    logic [6:0] a;
    void'($urandom(32'h5ffc_d86e));
    rst_n         = 1'b0;
    host_scl      = 1'b1;
    host_sda      = 1'b1;
    target_enable = 1'b1;
    addr0 = 7'h50;
    mask0 = 7'h7c;  // low two bits don't care
    addr1 = 7'h1a;
    mask1 = 7'h7f;
    thd_dat  = 16'd3;
    tx_wr    = 1'b0;
    tx_wdata = 8'h00;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    check_val(32'(target_rnw), 32'(0), "rnw after reset");
    idle_check("reset");
    for (int t = 0; t < NumTrans; t++) begin
      kind = $urandom_range(0, 3);
      a    = pick_match_addr();
      n    = $urandom_range(1, TxDepth);
      case (kind)
        0: write_txn(a, $urandom_range(1, 6), 1'b1);
        1: begin
          for (int i = 0; i < n; i++) push_tx(8'($urandom));
          read_txn(a, n, 1'b0);
        end
        2: begin
          write_txn(a, $urandom_range(1, 3), 1'b0);
          for (int i = 0; i < n; i++) push_tx(8'($urandom));
          bus_start();  // repeated start into the read
          read_txn(a, n, 1'b1);
        end
        default: begin
          a = 7'($urandom);
          if (addr_matches(a)) write_txn(a, 2, 1'b1);
          else nomatch_txn(a);
        end
      endcase
    end
    // disabled target ignores its own address
    @(posedge clk);
    target_enable <= 1'b0;
    nomatch_txn(addr1);
    @(posedge clk);
    target_enable <= 1'b1;
    // log longer than the fifo with nobody popping
    wait_drained();
    @(posedge clk);
    drain_en     <= 1'b0;
    stretch_seen <= 1'b0;
    write_txn(addr1, AcqDepth + 1, 1'b1);
    check_val(32'(stretch_seen), 32'(1), "stretch on full acquisition fifo");
    check_val(32'(acq_level), 32'(AcqDepth), "acquisition level while full");
    @(posedge clk);
    drain_en <= 1'b1;
    empty_tx_read(addr0);
    wait_drained();
    wait_clk(10);
    check_val(32'(acq_level), 32'(0), "acquisition level when drained");
    check_val(32'(cpl_cnt), 32'(exp_stops), "command complete count");
    check_val(32'(txq.size()), 32'(0), "tx bytes left over");
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: design/i2c_target_top.sv
`timescale 1ns/100ps

module i2c_target_top #(
  parameter  int AcqDepth = 8,
  parameter  int TxDepth  = 4,
  localparam int AcqLvlW  = $clog2(AcqDepth + 1)
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scl_i,
  input  logic                       sda_i,
  input  logic                       target_enable_i,
  input  logic [6:0]                 target_address0_i,
  input  logic [6:0]                 target_mask0_i,
  input  logic [6:0]                 target_address1_i,
  input  logic [6:0]                 target_mask1_i,
  input  logic [15:0]                thd_dat_i,
  input  logic                       tx_wr_i,      // push one tx byte
  input  logic [7:0]                 tx_wdata_i,
  input  logic                       acq_rd_i,     // pop one acq entry
  output logic                       scl_o,        // open drain, 0 = pull low
  output logic                       sda_o,
  output i2c_target_pkg::acq_entry_t acq_rdata_o,
  output logic                       acq_empty_o,
  output logic [AcqLvlW-1:0]         acq_level_o,
  output logic                       target_idle_o,
  output logic                       target_rnw_o,
  output logic                       event_cmd_complete_o,
  output logic                       event_stretch_o
);

  i2c_target_pkg::bus_event_t bus;
  i2c_target_pkg::acq_entry_t acq_wdata;
  logic                       acq_push;
  logic                       acq_full;
  logic                       tx_pop;
  logic                       tx_empty;
  logic [7:0]                 tx_rdata;

  i2c_bus_monitor u_monitor (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (scl_i),
    .sda_i  (sda_i),
    .bus_o  (bus)
  );

  i2c_target_fsm u_fsm (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .bus_i                (bus),
    .target_enable_i      (target_enable_i),
    .target_address0_i    (target_address0_i),
    .target_mask0_i       (target_mask0_i),
    .target_address1_i    (target_address1_i),
    .target_mask1_i       (target_mask1_i),
    .thd_dat_i            (thd_dat_i),
    .tx_empty_i           (tx_empty),
    .tx_rdata_i           (tx_rdata),
    .acq_full_i           (acq_full),
    .scl_o                (scl_o),
    .sda_o                (sda_o),
    .tx_pop_o             (tx_pop),
    .acq_push_o           (acq_push),
    .acq_wdata_o          (acq_wdata),
    .target_idle_o        (target_idle_o),
    .target_rnw_o         (target_rnw_o),
    .event_cmd_complete_o (event_cmd_complete_o),
    .event_stretch_o      (event_stretch_o)
  );

  // tagged log of the bus, read by the controller
  i2c_byte_fifo #(
    .Width (i2c_target_pkg::AcqWidth),
    .Depth (AcqDepth)
  ) u_acq_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_i    (acq_push),
    .wdata_i (acq_wdata),
    .rd_i    (acq_rd_i),
    .rdata_o (acq_rdata_o),
    .empty_o (acq_empty_o),
    .full_o  (acq_full),
    .level_o (acq_level_o)
  );

  // read data queue, filled by the controller
  i2c_byte_fifo #(
    .Width (8),
    .Depth (TxDepth)
  ) u_tx_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_i    (tx_wr_i),
    .wdata_i (tx_wdata_i),
    .rd_i    (tx_pop),
    .rdata_o (tx_rdata),
    .empty_o (tx_empty),
    .full_o  (),
    .level_o ()
  );

endmodule

// File: design/i2c_target_fsm.sv
`timescale 1ns/100ps

module i2c_target_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i2c_target_pkg::bus_event_t bus_i,              // from the bus monitor
  input  logic                       target_enable_i,
  input  logic [6:0]                 target_address0_i,
  input  logic [6:0]                 target_mask0_i,     // 1 = bit compared
  input  logic [6:0]                 target_address1_i,
  input  logic [6:0]                 target_mask1_i,
  input  logic [15:0]                thd_dat_i,          // sda hold after scl fall, clocks
  input  logic                       tx_empty_i,
  input  logic [7:0]                 tx_rdata_i,         // tx queue head
  input  logic                       acq_full_i,
  output logic                       scl_o,              // 0 = pull low
  output logic                       sda_o,              // 0 = pull low
  output logic                       tx_pop_o,
  output logic                       acq_push_o,
  output i2c_target_pkg::acq_entry_t acq_wdata_o,
  output logic                       target_idle_o,
  output logic                       target_rnw_o,
  output logic                       event_cmd_complete_o,
  output logic                       event_stretch_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_ADDR_ACK,
    ST_WR_BYTE,
    ST_WR_ACK,
    ST_RD_BYTE,
    ST_RD_ACK,
    ST_STRETCH
  } state_e;

  state_e                     state_q;
  state_e                     ret_state_q;   // where to go when stretch ends
  state_e                     fall_state;
  logic [3:0]                 bit_cnt_q;     // 0..7 bits, 8..10 ack slot phases
  logic [3:0]                 ret_cnt_q;
  logic [3:0]                 fall_cnt;
  logic [7:0]                 shift_q;
  logic [7:0]                 byte_next;     // shift_q with the sampled bit
  logic                       active_q;      // inside a matched transaction
  logic                       restart_q;     // current address follows a restart
  logic                       rnw_q;
  logic                       nack_q;        // host nack on last read byte
  logic                       sda_q;
  logic                       sda_pend_q;    // value waiting for hold time
  logic                       hold_act_q;
  logic [15:0]                hold_cnt_q;
  logic                       ret_sda_q;
  logic                       ret_load_q;
  logic                       fall_sda;
  logic                       fall_load;     // tx byte loaded at this fall
  logic                       stretch_req;
  logic                       tx_pop_q;
  logic                       cmd_cpl_q;
  logic                       addr_match;
  logic                       due;           // acquisition entry produced this cycle
  logic                       push_pend;
  logic                       push_due;
  logic                       pend_q;        // entry waiting for fifo space
  logic                       acq_push_q;
  i2c_target_pkg::acq_addr_t  rx_addr;
  i2c_target_pkg::acq_entry_t due_entry;
  i2c_target_pkg::acq_entry_t pend_entry_q;
  i2c_target_pkg::acq_entry_t acq_wdata_q;

  function automatic logic addr_hit(input logic [6:0] addr, input logic [6:0] tgt,
                                    input logic [6:0] mask);
    return ((addr ^ tgt) & mask) == 7'd0;  // mask 0 bits are don't care
  endfunction

  assign byte_next  = {shift_q[6:0], bus_i.sda};
  assign rx_addr    = i2c_target_pkg::acq_addr_t'(byte_next);
  assign addr_match = addr_hit(rx_addr.addr, target_address0_i, target_mask0_i) |
                      addr_hit(rx_addr.addr, target_address1_i, target_mask1_i);

  // entries to log
  always_comb begin
    due                      = 1'b0;
    due_entry.tag            = i2c_target_pkg::ACQ_STOP;
    due_entry.data.data_byte = 8'h00;
    if (bus_i.stop && active_q) begin
      due = 1'b1;  // stop closes our transaction
    end else if (bus_i.scl_rise && bit_cnt_q == 4'd7) begin
      if (state_q == ST_ADDR && addr_match) begin
        due                 = 1'b1;
        due_entry.tag       = i2c_target_pkg::ACQ_START;
        due_entry.data.addr = rx_addr;
        if (restart_q) begin
          due_entry.tag = i2c_target_pkg::ACQ_RESTART;
        end
      end else if (state_q == ST_WR_BYTE) begin
        due                      = 1'b1;
        due_entry.tag            = i2c_target_pkg::ACQ_DATA;
        due_entry.data.data_byte = byte_next;
      end
    end
  end

  // what an scl fall does in each state
  always_comb begin
    fall_state = state_q;
    fall_cnt   = bit_cnt_q;
    fall_sda   = 1'b1;  // released unless driven below
    fall_load  = 1'b0;
    unique case (state_q)
      ST_ADDR_ACK, ST_WR_ACK: begin
        if (bit_cnt_q == 4'd8) begin
          fall_cnt = 4'd9;  // ack slot starts, pull sda
          fall_sda = 1'b0;
        end else if (state_q == ST_ADDR_ACK && rnw_q) begin
          fall_state = ST_RD_BYTE;
          fall_cnt   = 4'd0;
          fall_load  = 1'b1;
          fall_sda   = tx_rdata_i[7];
        end else begin
          fall_state = ST_WR_BYTE;
          fall_cnt   = 4'd0;
        end
      end
      ST_RD_BYTE: fall_sda = shift_q[6];  // next bit, msb first
      ST_RD_ACK: begin
        if (bit_cnt_q == 4'd8) begin
          fall_cnt = 4'd9;  // release for host ack
        end else if (bit_cnt_q == 4'd10 && !nack_q) begin
          fall_state = ST_RD_BYTE;
          fall_cnt   = 4'd0;
          fall_load  = 1'b1;
          fall_sda   = tx_rdata_i[7];
        end
      end
      default: ;
    endcase
  end

  assign stretch_req = (pend_q & acq_full_i) | (fall_load & tx_empty_i);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= ST_IDLE;
      ret_state_q <= ST_IDLE;
      bit_cnt_q   <= 4'd0;
      ret_cnt_q   <= 4'd0;
      shift_q     <= 8'h00;
      active_q    <= 1'b0;
      restart_q   <= 1'b0;
      rnw_q       <= 1'b0;
      nack_q      <= 1'b0;
      sda_q       <= 1'b1;
      sda_pend_q  <= 1'b1;
      hold_act_q  <= 1'b0;
      hold_cnt_q  <= 16'd0;
      ret_sda_q   <= 1'b1;
      ret_load_q  <= 1'b0;
      tx_pop_q    <= 1'b0;
      cmd_cpl_q   <= 1'b0;
    end else begin
      tx_pop_q  <= 1'b0;
      cmd_cpl_q <= bus_i.stop & active_q;
      if (hold_act_q) begin  // hold timer, sda moves when it runs out
        hold_cnt_q <= hold_cnt_q - 16'd1;
        if (hold_cnt_q == 16'd1) begin
          sda_q      <= sda_pend_q;
          hold_act_q <= 1'b0;
        end
      end
      if (bus_i.stop) begin
        state_q    <= ST_IDLE;
        active_q   <= 1'b0;
        rnw_q      <= 1'b0;
        sda_q      <= 1'b1;
        hold_act_q <= 1'b0;
      end else if (bus_i.start) begin
        state_q    <= target_enable_i ? ST_ADDR : ST_IDLE;  // disabled target stays idle
        bit_cnt_q  <= 4'd0;
        restart_q  <= active_q;
        sda_q      <= 1'b1;
        hold_act_q <= 1'b0;
      end else if (state_q == ST_STRETCH) begin
        // line still held low by us, release once the cause is gone
        if (!pend_q && !(ret_load_q && tx_empty_i) && !bus_i.scl) begin
          state_q   <= ret_state_q;
          bit_cnt_q <= ret_cnt_q;
          if (ret_load_q) begin
            shift_q  <= tx_rdata_i;
            sda_q    <= tx_rdata_i[7];
            tx_pop_q <= 1'b1;
          end else begin
            sda_q <= ret_sda_q;
          end
        end
      end else if (bus_i.scl_rise && state_q != ST_IDLE) begin
        unique case (state_q)
          ST_ADDR: begin
            shift_q   <= byte_next;
            bit_cnt_q <= bit_cnt_q + 4'd1;
            if (bit_cnt_q == 4'd7) begin
              state_q  <= addr_match ? ST_ADDR_ACK : ST_IDLE;  // no ack on a miss
              active_q <= addr_match;
              rnw_q    <= rx_addr.rnw;
            end
          end
          ST_WR_BYTE: begin
            shift_q   <= byte_next;
            bit_cnt_q <= bit_cnt_q + 4'd1;
            if (bit_cnt_q == 4'd7) begin
              state_q <= ST_WR_ACK;
            end
          end
          ST_RD_BYTE: begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
            if (bit_cnt_q == 4'd7) begin
              state_q <= ST_RD_ACK;
            end
          end
          ST_RD_ACK: begin
            if (bit_cnt_q == 4'd9) begin
              nack_q    <= bus_i.sda;  // host sample point of ack slot
              bit_cnt_q <= 4'd10;
            end
          end
          default: ;
        endcase
      end else if (bus_i.scl_fall && state_q != ST_IDLE) begin
        if (state_q == ST_RD_BYTE) begin
          shift_q <= {shift_q[6:0], 1'b0};
        end
        if (stretch_req) begin
          state_q     <= ST_STRETCH;  // hold scl low from here
          ret_state_q <= fall_state;
          ret_cnt_q   <= fall_cnt;
          ret_sda_q   <= fall_sda;
          ret_load_q  <= fall_load;
          hold_act_q  <= 1'b0;
        end else begin
          state_q   <= fall_state;
          bit_cnt_q <= fall_cnt;
          if (fall_load) begin
            shift_q  <= tx_rdata_i;
            tx_pop_q <= 1'b1;
          end
          if (thd_dat_i == 16'd0) begin
            sda_q      <= fall_sda;
            hold_act_q <= 1'b0;
          end else begin
            hold_cnt_q <= thd_dat_i;
            sda_pend_q <= fall_sda;
            hold_act_q <= 1'b1;
          end
        end
      end
    end
  end

  // acquisition push, a blocked entry waits in pend until space
  assign push_pend = pend_q & ~acq_full_i;
  assign push_due  = due & ~pend_q & ~acq_full_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pend_q     <= 1'b0;
      acq_push_q <= 1'b0;
    end else begin
      acq_push_q <= push_pend | push_due;
      pend_q     <= (pend_q & acq_full_i) | (due & ~push_due);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_pend) begin
      acq_wdata_q <= pend_entry_q;
    end else if (push_due) begin
      acq_wdata_q <= due_entry;
    end
    if (due && !push_due) begin
      pend_entry_q <= due_entry;
    end
  end

  assign scl_o                = (state_q != ST_STRETCH);
  assign event_stretch_o      = (state_q == ST_STRETCH);
  assign sda_o                = sda_q;
  assign tx_pop_o             = tx_pop_q;
  assign acq_push_o           = acq_push_q;
  assign acq_wdata_o          = acq_wdata_q;
  assign target_idle_o        = (state_q == ST_IDLE);
  assign target_rnw_o         = rnw_q;
  assign event_cmd_complete_o = cmd_cpl_q;

endmodule

// File: design/i2c_byte_fifo.sv
`timescale 1ns/100ps

module i2c_byte_fifo #(
  parameter  int Width = 8,
  parameter  int Depth = 4,
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1,
  localparam int LvlW  = $clog2(Depth + 1)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wr_i,     // push strobe
  input  logic [Width-1:0] wdata_i,
  input  logic             rd_i,     // pop strobe
  output logic [Width-1:0] rdata_o,  // head, shown ahead
  output logic             empty_o,
  output logic             full_o,
  output logic [LvlW-1:0]  level_o
);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [LvlW-1:0]  level_q;
  logic             do_wr;
  logic             do_rd;

  assign empty_o = (level_q == '0);
  assign full_o  = (level_q == LvlW'(Depth));
  assign level_o = level_q;
  assign rdata_o = mem_q[rd_ptr_q];

  assign do_wr = wr_i & ~full_o;   // write to full is dropped
  assign do_rd = rd_i & ~empty_o;  // pop on empty is ignored

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // level moves only when exactly one side acts
      if (do_wr && !do_rd) begin
        level_q <= level_q + 1'b1;
      end else if (do_rd && !do_wr) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

// File: design/i2c_bus_monitor.sv
`timescale 1ns/100ps

module i2c_bus_monitor (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scl_i,  // raw bus clock
  input  logic                       sda_i,  // raw bus data
  output i2c_target_pkg::bus_event_t bus_o   // decoded edges and conditions
);

  logic scl_q;   // first register on the pin
  logic sda_q;
  logic scl_qq;  // previous registered value
  logic sda_qq;

  // idle bus is high on both lines, so reset to 1 to avoid a false edge
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      scl_q  <= 1'b1;
      sda_q  <= 1'b1;
      scl_qq <= 1'b1;
      sda_qq <= 1'b1;
    end else begin
      scl_q  <= scl_i;
      sda_q  <= sda_i;
      scl_qq <= scl_q;   // keep last sample for edge compare
      sda_qq <= sda_q;
    end
  end

  logic scl_high;  // scl stayed high over both samples
  logic sda_fell;
  logic sda_rose;

  assign scl_high = scl_q & scl_qq;
  assign sda_fell = sda_qq & ~sda_q;
  assign sda_rose = ~sda_qq & sda_q;

  always_comb begin
    bus_o.scl_rise = scl_q & ~scl_qq;    // low to high
    bus_o.scl_fall = ~scl_q & scl_qq;    // high to low
    bus_o.start    = scl_high & sda_fell;  // also covers repeated start
    bus_o.stop     = scl_high & sda_rose;
    bus_o.scl      = scl_q;
    bus_o.sda      = sda_q;
  end

endmodule

// File: design/i2c_target_pkg.sv
package i2c_target_pkg;

  // kind of an acquisition entry
  typedef enum logic [1:0] {
    ACQ_START   = 2'd0,  // address byte after start
    ACQ_DATA    = 2'd1,  // write byte from the host
    ACQ_RESTART = 2'd2,  // address byte after repeated start
    ACQ_STOP    = 2'd3   // stop, data is zero
  } acq_tag_e;

  // address byte as seen on the wire, msb first
  typedef struct packed {
    logic [6:0] addr;  // 7-bit target address
    logic       rnw;   // 1 = host reads
  } acq_addr_t;

  // one byte, decoded by the tag
  typedef union packed {
    acq_addr_t  addr;       // ACQ_START / ACQ_RESTART
    logic [7:0] data_byte;  // ACQ_DATA, zero for ACQ_STOP
  } acq_data_u;

  typedef struct packed {
    acq_tag_e  tag;
    acq_data_u data;
  } acq_entry_t;

  localparam int AcqWidth = $bits(acq_entry_t);  // 10

  // monitor to fsm, strobes are one cycle wide
  typedef struct packed {
    logic scl_rise;  // strobe
    logic scl_fall;  // strobe
    logic start;     // strobe, sda fell with scl high
    logic stop;      // strobe, sda rose with scl high
    logic scl;       // registered level
    logic sda;       // registered level
  } bus_event_t;

endpackage
